// ==== run_sim.sh ====
#!/bin/sh
# Build the trap logger testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_trap_log -f sim.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

// ==== sim.f ====
+incdir+src
src/trap_log_pkg.sv
src/trap_cause_decoder.sv
src/first_trap_recorder.sv
src/trap_log_wb_slave.sv
src/trap_log_top.sv
testbench/tb_trap_log.sv

// ==== src/first_trap_recorder.sv ====
// First trap recorder
// Keeps one found flag and one captured PC per exception cause.
// Only the first hit of a cause is recorded, later hits are ignored
// until the host re-arms the cause with a write-one-to-clear mask.

`timescale 1ns/1ps

`include "trap_log_settings.svh"

module first_trap_recorder (
  input  logic                                     clk,
  input  logic                                     rst_ni,
  input  trap_log_pkg::trap_hit_t                  hit_i,
  input  trap_log_pkg::cause_mask_t                clear_mask_i,
  output trap_log_pkg::cause_mask_t                found_o,
  output trap_log_pkg::pc_t [`TL_NUM_CAUSES-1:0]   pc_table_o
);

  trap_log_pkg::cause_mask_t              hit_mask;
  trap_log_pkg::cause_mask_t              capture;
  trap_log_pkg::cause_mask_t              found_d;
  trap_log_pkg::cause_mask_t              found_q;
  trap_log_pkg::pc_t [`TL_NUM_CAUSES-1:0] pc_q;

  //////////////////////////////////////////////////
  // Flag update
  //////////////////////////////////////////////////

  // One-hot view of the incoming hit, empty when there is no hit
  assign hit_mask = hit_i.valid ? (trap_log_pkg::cause_mask_t'(1) << hit_i.cause) : '0;

  // Capture on a fresh cause, or when a clear of that cause lands in the
  // same cycle, since the hit takes precedence over the clear
  assign capture = hit_mask & (~found_q | clear_mask_i);

  // A hit sets its flag, a clear bit drops it unless a hit overrides
  assign found_d = hit_mask | (found_q & ~clear_mask_i);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_d;
    end
  end

  //////////////////////////////////////////////////
  // Captured PCs
  //////////////////////////////////////////////////

  // PC registers read back as zero until their cause is first seen
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else begin
      for (int i = 0; i < `TL_NUM_CAUSES; i++) begin
        if (capture[i]) begin
          pc_q[i] <= hit_i.pc;
        end
      end
    end
  end

  assign found_o    = found_q;
  assign pc_table_o = pc_q;

  // A recorded cause only goes away through a clear from the register block
  for (genvar g = 0; g < `TL_NUM_CAUSES; g++) begin : g_flag_chk
    a_flag_held : assert property (@(posedge clk) disable iff (!rst_ni)
      (found_q[g] && !clear_mask_i[g]) |=> found_q[g]);
  end

endmodule

// ==== src/trap_cause_decoder.sv ====
// Trap cause decoder
// Turns one retire event per cycle into at most one exception hit.
// Events that coincide with an interrupt acknowledge, a debug entry or
// an NMI are dropped, the rest are resolved by exception priority and
// registered together with their PC.

`timescale 1ns/1ps

module trap_cause_decoder (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  trap_log_pkg::retire_event_t event_i,
  output trap_log_pkg::trap_hit_t     hit_o
);

  logic                     suppress;
  logic                     exc_any;
  logic                     hit_valid_d;
  trap_log_pkg::cause_idx_e cause_d;
  logic                     hit_valid_q;
  trap_log_pkg::cause_idx_e cause_q;
  trap_log_pkg::pc_t        pc_q;

  //////////////////////////////////////////////////
  // Suppression and priority decode
  //////////////////////////////////////////////////

  // An interrupt, debug entry or NMI takes the trap slot in this cycle
  assign suppress = event_i.irq_ack | event_i.dbg_entry | event_i.nmi;

  // Any synchronous exception source at all
  assign exc_any = event_i.mpu_err | event_i.bus_err | event_i.illegal |
                   event_i.ecall | event_i.ebreak;

  assign hit_valid_d = event_i.valid & ~suppress & exc_any;

  // Highest priority first, EBREAK is what remains when nothing above fired
  always_comb begin
    cause_d = trap_log_pkg::CAUSE_EBREAK;
    if (event_i.mpu_err) begin
      cause_d = trap_log_pkg::CAUSE_INSTR_MPU;
    end else if (event_i.bus_err) begin
      cause_d = trap_log_pkg::CAUSE_INSTR_BUS;
    end else if (event_i.illegal) begin
      cause_d = trap_log_pkg::CAUSE_ILLEGAL;
    end else if (event_i.ecall) begin
      // ECALL cause depends on the privilege it was issued from
      if (event_i.priv == trap_log_pkg::PRIV_LVL_M) begin
        cause_d = trap_log_pkg::CAUSE_ECALL_M;
      end else begin
        cause_d = trap_log_pkg::CAUSE_ECALL_U;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_valid_q <= 1'b0;
    end else begin
      hit_valid_q <= hit_valid_d;
    end
  end

  // Cause and PC only move when a real hit is decoded
  always_ff @(posedge clk) begin
    if (hit_valid_d) begin
      cause_q <= cause_d;
      pc_q    <= event_i.pc;
    end
  end

  assign hit_o.valid = hit_valid_q;
  assign hit_o.cause = cause_q;
  assign hit_o.pc    = pc_q;

  // A suppressed retire must never surface as a hit one cycle later
  a_no_hit_after_suppress : assert property (@(posedge clk) disable iff (!rst_ni)
    (event_i.valid && suppress) |=> !hit_o.valid);

endmodule

// ==== src/trap_log_pkg.sv ====
// Trap-entry logger shared types
// Vector typedefs, enums and packed structs used by every block of the
// logger and by its testbench

`include "trap_log_settings.svh"

package trap_log_pkg;

  //////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////

  // Instruction address of a retiring instruction
  typedef logic [`TL_XLEN-1:0] pc_t;

  // Wishbone data word and word address
  typedef logic [`TL_XLEN-1:0]   wb_data_t;
  typedef logic [`TL_ADDR_W-1:0] wb_addr_t;

  // One bit per logged cause, bit index equals cause index
  typedef logic [`TL_NUM_CAUSES-1:0] cause_mask_t;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // Privilege level encoding follows the RISC-V mstatus.mpp values
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Cause index doubles as the word address of that cause's PC register
  // Listed from highest to lowest exception priority
  typedef enum logic [2:0] {
    CAUSE_INSTR_MPU = 3'd0,
    CAUSE_INSTR_BUS = 3'd1,
    CAUSE_ILLEGAL   = 3'd2,
    CAUSE_ECALL_M   = 3'd3,
    CAUSE_ECALL_U   = 3'd4,
    CAUSE_EBREAK    = 3'd5
  } cause_idx_e;

  // Wishbone slave FSM, idle or presenting the single ack cycle
  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_e;

  //////////////////////////////////////////////////
  // Packed structs
  //////////////////////////////////////////////////

  // One retiring instruction as seen at writeback
  // The flags after valid only mean something while valid is high
  typedef struct packed {
    logic      valid;
    pc_t       pc;
    logic      illegal;
    logic      ecall;
    logic      ebreak;
    logic      bus_err;
    logic      mpu_err;
    priv_lvl_e priv;
    logic      irq_ack;
    logic      dbg_entry;
    logic      nmi;
  } retire_event_t;

  // Decoded exception, at most one per cycle
  typedef struct packed {
    logic       valid;
    cause_idx_e cause;
    pc_t        pc;
  } trap_hit_t;

  // Wishbone classic request from the master and response from the slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

// ==== src/trap_log_settings.svh ====
// Trap-entry logger global settings
// Widths and the register map constants used by the package and the RTL
// The cause count fixes both the PC register range and the status address

`ifndef TRAP_LOG_SETTINGS_SVH
`define TRAP_LOG_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Width of an instruction address and of a Wishbone data word
`define TL_XLEN 32

// Number of synchronous exception causes that get logged
`define TL_NUM_CAUSES 6

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Wishbone word-address width, enough for the PCs plus status
`define TL_ADDR_W 3

// Status register sits right after the last per-cause PC register
`define TL_STATUS_ADDR 6

`endif

// ==== src/trap_log_top.sv ====
// Trap-entry logger top level
// Retire events pass through the cause decoder into the first trap
// recorder, and the host reads and re-arms the log through the
// Wishbone register block.

`timescale 1ns/1ps

`include "trap_log_settings.svh"

module trap_log_top (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  trap_log_pkg::retire_event_t event_i,
  input  trap_log_pkg::wb_req_t       wb_req_i,
  output trap_log_pkg::wb_rsp_t       wb_rsp_o
);

  trap_log_pkg::trap_hit_t                hit;
  trap_log_pkg::cause_mask_t              found;
  trap_log_pkg::pc_t [`TL_NUM_CAUSES-1:0] pc_table;
  trap_log_pkg::cause_mask_t              clear_mask;

  // Decode stage, one cycle from event to hit
  trap_cause_decoder trap_cause_decoder_i (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .event_i (event_i),
    .hit_o   (hit)
  );

  // Record stage, one more cycle until flags and PCs are visible
  first_trap_recorder first_trap_recorder_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .hit_i        (hit),
    .clear_mask_i (clear_mask),
    .found_o      (found),
    .pc_table_o   (pc_table)
  );

  // Host side register access and re-arm
  trap_log_wb_slave trap_log_wb_slave_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .found_i      (found),
    .pc_table_i   (pc_table),
    .clear_mask_o (clear_mask)
  );

endmodule

// ==== src/trap_log_wb_slave.sv ====
// Trap log register block
// Wishbone classic slave in front of the first trap recorder.
// Word addresses below the cause count return the captured PCs, the
// status word returns the found mask, and a status write re-arms every
// cause whose data bit is set.

`timescale 1ns/1ps

`include "trap_log_settings.svh"

module trap_log_wb_slave (
  input  logic                                   clk,
  input  logic                                   rst_ni,
  input  trap_log_pkg::wb_req_t                  wb_req_i,
  output trap_log_pkg::wb_rsp_t                  wb_rsp_o,
  input  trap_log_pkg::cause_mask_t              found_i,
  input  trap_log_pkg::pc_t [`TL_NUM_CAUSES-1:0] pc_table_i,
  output trap_log_pkg::cause_mask_t              clear_mask_o
);

  trap_log_pkg::wb_state_e   state_q;
  trap_log_pkg::wb_state_e   state_d;
  logic                      req_accept;
  logic                      status_sel;
  trap_log_pkg::wb_data_t    rdata_d;
  trap_log_pkg::wb_data_t    rdata_q;
  trap_log_pkg::cause_mask_t clear_d;
  trap_log_pkg::cause_mask_t clear_q;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  // A new request is only taken while no ack is pending
  assign req_accept = (state_q == trap_log_pkg::WB_IDLE) && wb_req_i.cyc && wb_req_i.stb;

  assign status_sel = (wb_req_i.adr == trap_log_pkg::wb_addr_t'(`TL_STATUS_ADDR));

  always_comb begin
    state_d = state_q;
    case (state_q)
      trap_log_pkg::WB_IDLE: begin
        if (req_accept) begin
          state_d = trap_log_pkg::WB_ACK;
        end
      end
      // Ack lasts exactly one cycle
      trap_log_pkg::WB_ACK: begin
        state_d = trap_log_pkg::WB_IDLE;
      end
      default: begin
        state_d = trap_log_pkg::WB_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Read data reflects recorder state at the edge the request is taken
  always_comb begin
    rdata_d = '0;
    if (wb_req_i.adr < trap_log_pkg::wb_addr_t'(`TL_NUM_CAUSES)) begin
      rdata_d = pc_table_i[wb_req_i.adr];
    end else if (status_sel) begin
      rdata_d = {{(`TL_XLEN-`TL_NUM_CAUSES){1'b0}}, found_i};
    end
  end

  // PC registers are read-only, only the status word takes writes
  assign clear_d = (req_accept && wb_req_i.we && status_sel) ?
                   wb_req_i.dat[`TL_NUM_CAUSES-1:0] : '0;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= trap_log_pkg::WB_IDLE;
      clear_q <= '0;
    end else begin
      state_q <= state_d;
      clear_q <= clear_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack  = (state_q == trap_log_pkg::WB_ACK);
  assign wb_rsp_o.dat  = rdata_q;
  assign clear_mask_o  = clear_q;

  // Ack answers a live cycle and is followed by at least one idle cycle
  a_single_ack : assert property (@(posedge clk) disable iff (!rst_ni)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb) ##1 !wb_rsp_o.ack);

endmodule

// ==== testbench/tb_trap_log.sv ====
// Trap-entry logger testbench
// Drives retire events and Wishbone accesses into the logger and checks
// every register against a reference model of the decode and record rules

`timescale 1ns/1ps

`include "trap_log_settings.svh"

module tb_trap_log;

  // Exception flag groups in the order mpu, bus, illegal, ecall, ebreak
  localparam logic [4:0] EXC_MPU   = 5'b10000;
  localparam logic [4:0] EXC_BUS   = 5'b01000;
  localparam logic [4:0] EXC_ILL   = 5'b00100;
  localparam logic [4:0] EXC_ECALL = 5'b00010;
  localparam logic [4:0] EXC_EBRK  = 5'b00001;
  localparam trap_log_pkg::priv_lvl_e PRIV_M = trap_log_pkg::PRIV_LVL_M;
  localparam trap_log_pkg::priv_lvl_e PRIV_U = trap_log_pkg::PRIV_LVL_U;

  logic                        clk;
  logic                        rst_ni;
  trap_log_pkg::retire_event_t event_r;
  trap_log_pkg::wb_req_t       wb_req_r;
  trap_log_pkg::wb_rsp_t       wb_rsp;

  // Reference state and the decoded hits still travelling through the DUT
  trap_log_pkg::cause_mask_t   exp_found;
  trap_log_pkg::pc_t           exp_pc [`TL_NUM_CAUSES];
  trap_log_pkg::trap_hit_t     pend_q [$];

  trap_log_top trap_log_top_i (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .event_i  (event_r),
    .wb_req_i (wb_req_r),
    .wb_rsp_o (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Sized for reset, four directed blocks of up to 400 cycles and the random run
  initial begin
    #((8 + 4 * 400 + 400) * 100);
    $display("Timeout: the run did not finish in the expected time");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Suppression first, then causes from highest to lowest priority
  function automatic trap_log_pkg::trap_hit_t ref_cause(input trap_log_pkg::retire_event_t ev);
    trap_log_pkg::trap_hit_t h;
    h.valid = 1'b0;
    h.cause = trap_log_pkg::CAUSE_EBREAK;
    h.pc    = ev.pc;
    if (ev.valid && !ev.irq_ack && !ev.dbg_entry && !ev.nmi) begin
      h.valid = 1'b1;
      if (ev.mpu_err) h.cause = trap_log_pkg::CAUSE_INSTR_MPU;
      else if (ev.bus_err) h.cause = trap_log_pkg::CAUSE_INSTR_BUS;
      else if (ev.illegal) h.cause = trap_log_pkg::CAUSE_ILLEGAL;
      else if (ev.ecall) h.cause = (ev.priv == PRIV_M) ? trap_log_pkg::CAUSE_ECALL_M :
                                                          trap_log_pkg::CAUSE_ECALL_U;
      else if (!ev.ebreak) h.valid = 1'b0;
    end
    return h;
  endfunction

  function automatic trap_log_pkg::retire_event_t mk_event(input trap_log_pkg::pc_t pc,
    input logic [4:0] exc, input trap_log_pkg::priv_lvl_e priv, input logic [2:0] sup);
    trap_log_pkg::retire_event_t ev;
    ev.valid = 1'b1;
    ev.pc    = pc;
    {ev.mpu_err, ev.bus_err, ev.illegal, ev.ecall, ev.ebreak} = exc;
    ev.priv  = priv;
    {ev.irq_ack, ev.dbg_entry, ev.nmi} = sup;
    return ev;
  endfunction

  // Weighted so that every cause and every suppression source shows up
  function automatic trap_log_pkg::retire_event_t rand_event();
    trap_log_pkg::retire_event_t ev;
    logic [31:0]                 rnd;
    rnd          = $urandom;
    ev.valid     = ($urandom % 10) != 0;
    ev.pc        = {rnd[31:2], 2'b00};
    ev.mpu_err   = ($urandom % 7) == 0;
    ev.bus_err   = ($urandom % 7) == 0;
    ev.illegal   = ($urandom % 6) == 0;
    ev.ecall     = ($urandom % 4) == 0;
    ev.ebreak    = ($urandom % 4) == 0;
    ev.priv      = rnd[1] ? PRIV_M : PRIV_U;
    ev.irq_ack   = ($urandom % 12) == 0;
    ev.dbg_entry = ($urandom % 12) == 0;
    ev.nmi       = ($urandom % 12) == 0;
    return ev;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and bus tasks
  //////////////////////////////////////////////////

  task automatic send_event(input trap_log_pkg::retire_event_t ev);
    @(posedge clk);
    event_r <= ev;
    pend_q.push_back(ref_cause(ev));
  endtask

  // Two idle cycles cover the decode and record latency, then the model catches up
  task automatic settle();
    trap_log_pkg::trap_hit_t h;
    repeat (2) send_event('0);
    while (pend_q.size() > 0) begin
      h = pend_q.pop_front();
      if (h.valid && !exp_found[h.cause]) begin
        exp_found[h.cause] = 1'b1;
        exp_pc[h.cause]    = h.pc;
      end
    end
  endtask

  // Classic cycle, held until ack, with ack and data sampled on the falling edge
  task automatic wb_access(input logic we, input trap_log_pkg::wb_addr_t adr,
                           input trap_log_pkg::wb_data_t dat,
                           output trap_log_pkg::wb_data_t rdata);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk);
    wb_req_r <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 16) begin
        $display("Wishbone ack never arrived for word address %0d", adr);
        $display("Test failed");
        $fatal(1, "bus timeout");
      end
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    @(posedge clk);
    wb_req_r <= '0;
  endtask

  task automatic write_clear(input trap_log_pkg::cause_mask_t mask);
    trap_log_pkg::wb_data_t rd;
    wb_access(1'b1, trap_log_pkg::wb_addr_t'(`TL_STATUS_ADDR),
              trap_log_pkg::wb_data_t'(mask), rd);
    exp_found &= ~mask;
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_pc(input string name, input trap_log_pkg::pc_t got,
                          input trap_log_pkg::pc_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "PC mismatch");
    end
  endtask

  task automatic check_mask(input string name, input trap_log_pkg::cause_mask_t got,
                            input trap_log_pkg::cause_mask_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mask mismatch");
    end
  endtask

  task automatic check_data(input string name, input trap_log_pkg::wb_data_t got,
                            input trap_log_pkg::wb_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_status();
    trap_log_pkg::wb_data_t rd;
    wb_access(1'b0, trap_log_pkg::wb_addr_t'(`TL_STATUS_ADDR), '0, rd);
    check_mask("status.found", rd[`TL_NUM_CAUSES-1:0], exp_found);
    check_data("status.reserved", rd >> `TL_NUM_CAUSES, '0);
  endtask

  task automatic check_pc_reg(input int idx);
    trap_log_pkg::wb_data_t rd;
    wb_access(1'b0, trap_log_pkg::wb_addr_t'(idx), '0, rd);
    check_pc($sformatf("pc[%0d]", idx), rd, exp_pc[idx]);
  endtask

  // Sweep of the whole register map against the model
  task automatic compare_all();
    trap_log_pkg::wb_data_t rd;
    for (int i = 0; i < `TL_NUM_CAUSES; i++) check_pc_reg(i);
    check_status();
    wb_access(1'b0, trap_log_pkg::wb_addr_t'(7), '0, rd);
    check_data("reg7", rd, '0);
  endtask

  task automatic record_and_compare(input trap_log_pkg::pc_t pc, input logic [4:0] exc,
                                    input trap_log_pkg::priv_lvl_e priv);
    send_event(mk_event(pc, exc, priv, 3'b000));
    settle();
    compare_all();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    trap_log_pkg::retire_event_t ev;
    int                          sent;
    int                          burst;
    void'($urandom(32'hd71c));
    exp_found   = '0;
    foreach (exp_pc[i]) exp_pc[i] = '0;
    rst_ni   = 1'b0;
    event_r  = '0;
    wb_req_r = '0;
    repeat (8) @(posedge clk);
    rst_ni <= 1'b1;
    compare_all();

    // One event per cause, each with its own PC
    record_and_compare(32'h0000_1000, EXC_MPU, PRIV_M);
    record_and_compare(32'h0000_1104, EXC_BUS, PRIV_U);
    record_and_compare(32'h0000_1208, EXC_ILL, PRIV_M);
    record_and_compare(32'h0000_130c, EXC_ECALL, PRIV_M);
    record_and_compare(32'h0000_1410, EXC_ECALL, PRIV_U);
    record_and_compare(32'h0000_1514, EXC_EBRK, PRIV_U);

    // Several flags at once, back to back, only the top priority is logged
    write_clear('1);
    send_event(mk_event(32'h0000_2000, EXC_MPU | EXC_ILL | EXC_EBRK, PRIV_M, 3'b000));
    send_event(mk_event(32'h0000_2004, EXC_BUS | EXC_ECALL, PRIV_M, 3'b000));
    send_event(mk_event(32'h0000_2008, EXC_ECALL | EXC_EBRK, PRIV_U, 3'b000));
    settle();
    compare_all();

    // Interrupt, debug entry, NMI and invalid retires leave the log alone
    write_clear('1);
    send_event(mk_event(32'h0000_3000, EXC_ILL, PRIV_M, 3'b100));
    send_event(mk_event(32'h0000_3004, EXC_MPU, PRIV_M, 3'b010));
    send_event(mk_event(32'h0000_3008, EXC_EBRK, PRIV_U, 3'b001));
    ev = mk_event(32'h0000_300c, EXC_BUS, PRIV_M, 3'b000);
    ev.valid = 1'b0;
    send_event(ev);
    settle();
    compare_all();

    // The first PC of a cause sticks, then a clear re-arms only the masked causes
    record_and_compare(32'h0000_4000, EXC_ILL, PRIV_M);
    record_and_compare(32'h0000_4400, EXC_ILL, PRIV_U);
    record_and_compare(32'h0000_4800, EXC_EBRK, PRIV_M);
    record_and_compare(32'h0000_4900, EXC_MPU, PRIV_U);
    write_clear(6'b100100);
    compare_all();
    record_and_compare(32'h0000_4c00, EXC_ILL, PRIV_M);

    // Random bursts with idle gaps, status reads and random re-arms
    sent = 0;
    while (sent < 400) begin
      burst = 1 + int'($urandom % 12);
      for (int i = 0; i < burst && sent < 400; i++) begin
        if ($urandom % 4 == 0) send_event('0);
        send_event(rand_event());
        sent++;
      end
      settle();
      check_status();
      check_pc_reg(int'($urandom % `TL_NUM_CAUSES));
      if ($urandom % 2 == 0) write_clear(trap_log_pkg::cause_mask_t'($urandom));
    end
    settle();
    compare_all();

    $display("Test completed successfully");
    $finish;
  end

endmodule
